// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // integer register width
    localparam int unsigned XLEN = 32;

    // architectural register index, x0..x31
    typedef logic [4:0] reg_name_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    // func3 codes shared by OP and OP-IMM
    localparam logic [2:0] FUNC3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNC3_SLL     = 3'b001;
    localparam logic [2:0] FUNC3_SLT     = 3'b010;
    localparam logic [2:0] FUNC3_SLTU    = 3'b011;
    localparam logic [2:0] FUNC3_XOR     = 3'b100;
    localparam logic [2:0] FUNC3_SR      = 3'b101;
    localparam logic [2:0] FUNC3_OR      = 3'b110;
    localparam logic [2:0] FUNC3_AND     = 3'b111;

    // func7 with bit 30 set, selects sub and sra
    localparam logic [6:0] FUNC7_ALT = 7'b0100000;

endpackage

`default_nettype wire

// ==== hw/pipe_ctrl_pkg.sv ====
`default_nettype none

package pipe_ctrl_pkg;

    // operations understood by the execute ALU
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2
    } alu_op_t;

    // operand source; operand 1 uses REG/PC/ZERO, operand 2 uses REG/IMM
    typedef enum logic [1:0] {
        SEL_REG  = 2'd0,
        SEL_PC   = 2'd1,
        SEL_ZERO = 2'd2,
        SEL_IMM  = 2'd3
    } alu_sel_t;

    // IF/ID boundary
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        logic [31:0]                   instr;
    } if_id_t;

    // ID/EX boundary
    typedef struct packed {
        logic                          valid;
        logic [rv_isa_pkg::XLEN-1:0]   pc;
        alu_sel_t                      alu_src1;
        alu_sel_t                      alu_src2;
        alu_op_t                       alu_op;
        logic                          reg_write;
        logic [rv_isa_pkg::XLEN-1:0]   read1;
        logic [rv_isa_pkg::XLEN-1:0]   read2;
        // I or U immediate, already chosen
        logic [rv_isa_pkg::XLEN-1:0]   imm;
        rv_isa_pkg::reg_name_t         rd;
        rv_isa_pkg::reg_name_t         rs1;
        rv_isa_pkg::reg_name_t         rs2;
    } id_ex_t;

    // EX/WB boundary
    typedef struct packed {
        logic                          valid;
        logic                          reg_write;
        rv_isa_pkg::reg_name_t         rd;
        logic [rv_isa_pkg::XLEN-1:0]   result;
    } ex_wb_t;

endpackage

`default_nettype wire

// ==== hw/pipeline_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_register #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rstN,
    input  wire payload_t d,
    output payload_t      q
);

    // reset empties the stage, the valid bit drops with the rest
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire pipe_ctrl_pkg::if_id_t              if_id,
    output rv_isa_pkg::reg_name_t                   rs1,
    output rv_isa_pkg::reg_name_t                   rs2,
    input  wire logic [rv_isa_pkg::XLEN-1:0]        rdata1,
    input  wire logic [rv_isa_pkg::XLEN-1:0]        rdata2,
    output pipe_ctrl_pkg::id_ex_t                   id_ex
);

    logic [31:0]                   instr;
    rv_isa_pkg::opcode_t           opcode;
    logic [2:0]                    func3;
    logic [6:0]                    func7;
    logic                          alt;
    logic [rv_isa_pkg::XLEN-1:0]   imm_i;
    logic [rv_isa_pkg::XLEN-1:0]   imm_u;

    // map func3 to an ALU op; sub and sra are enabled separately
    function automatic pipe_ctrl_pkg::alu_op_t alu_op_decode(
        input logic [2:0] f3,
        input logic       sub_en,
        input logic       sra_en
    );
        pipe_ctrl_pkg::alu_op_t op;
        case (f3)
            rv_isa_pkg::FUNC3_ADD_SUB: op = sub_en ? pipe_ctrl_pkg::ALU_SUB
                                                   : pipe_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::FUNC3_SLL:     op = pipe_ctrl_pkg::ALU_SLL;
            rv_isa_pkg::FUNC3_SLT:     op = pipe_ctrl_pkg::ALU_SLT;
            rv_isa_pkg::FUNC3_SLTU:    op = pipe_ctrl_pkg::ALU_SLTU;
            rv_isa_pkg::FUNC3_XOR:     op = pipe_ctrl_pkg::ALU_XOR;
            rv_isa_pkg::FUNC3_SR:      op = sra_en ? pipe_ctrl_pkg::ALU_SRA
                                                   : pipe_ctrl_pkg::ALU_SRL;
            rv_isa_pkg::FUNC3_OR:      op = pipe_ctrl_pkg::ALU_OR;
            default:                   op = pipe_ctrl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    // instruction fields
    assign instr  = if_id.instr;
    assign opcode = rv_isa_pkg::opcode_t'(instr[6:0]);
    assign func3  = instr[14:12];
    assign func7  = instr[31:25];
    assign alt    = (func7 == rv_isa_pkg::FUNC7_ALT);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        id_ex           = '0;
        id_ex.valid     = if_id.valid;
        id_ex.pc        = if_id.pc;
        id_ex.read1     = rdata1;
        id_ex.read2     = rdata2;
        id_ex.rd        = instr[11:7];
        id_ex.rs1       = rs1;
        id_ex.rs2       = rs2;
        id_ex.reg_write = 1'b1;
        id_ex.alu_src1  = pipe_ctrl_pkg::SEL_REG;
        id_ex.alu_src2  = pipe_ctrl_pkg::SEL_REG;
        id_ex.alu_op    = pipe_ctrl_pkg::ALU_ADD;
        id_ex.imm       = imm_i;

        case (opcode)
            rv_isa_pkg::OPC_OP: begin
                id_ex.alu_op = alu_op_decode(func3, alt, alt);
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // no subi, func7 only matters for srai
                id_ex.alu_op   = alu_op_decode(func3, 1'b0, alt);
                id_ex.alu_src2 = pipe_ctrl_pkg::SEL_IMM;
            end
            rv_isa_pkg::OPC_LUI: begin
                id_ex.alu_op   = pipe_ctrl_pkg::ALU_PASS2;
                id_ex.alu_src1 = pipe_ctrl_pkg::SEL_ZERO;
                id_ex.alu_src2 = pipe_ctrl_pkg::SEL_IMM;
                id_ex.imm      = imm_u;
            end
            rv_isa_pkg::OPC_AUIPC: begin
                id_ex.alu_src1 = pipe_ctrl_pkg::SEL_PC;
                id_ex.alu_src2 = pipe_ctrl_pkg::SEL_IMM;
                id_ex.imm      = imm_u;
            end
            default: begin
                // unsupported, becomes a bubble
                id_ex.valid     = 1'b0;
                id_ex.reg_write = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire logic                           clk,
    input  wire logic                           rstN,
    input  wire rv_isa_pkg::reg_name_t          raddr1,
    input  wire rv_isa_pkg::reg_name_t          raddr2,
    output logic [rv_isa_pkg::XLEN-1:0]         rdata1,
    output logic [rv_isa_pkg::XLEN-1:0]         rdata2,
    input  wire logic                           we,
    input  wire rv_isa_pkg::reg_name_t          waddr,
    input  wire logic [rv_isa_pkg::XLEN-1:0]    wdata
);

    // x1..x31, x0 has no storage
    logic [rv_isa_pkg::XLEN-1:0] regs [1:31];

    // one read port with write-through of the same-cycle write
    function automatic logic [rv_isa_pkg::XLEN-1:0] read_port(
        input rv_isa_pkg::reg_name_t addr
    );
        logic [rv_isa_pkg::XLEN-1:0] value;
        if (addr == '0) begin
            value = '0;
        end else if (we && (addr == waddr)) begin
            value = wdata;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    // write port and storage feed the read ports as well as the addresses
    always_comb begin
        rdata1 = read_port(raddr1);
    end

    always_comb begin
        rdata2 = read_port(raddr2);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire pipe_ctrl_pkg::id_ex_t  id_ex,
    input  wire pipe_ctrl_pkg::ex_wb_t  fwd,
    output pipe_ctrl_pkg::ex_wb_t       ex_wb
);

    logic                          fwd_ok;
    logic [rv_isa_pkg::XLEN-1:0]   reg1;
    logic [rv_isa_pkg::XLEN-1:0]   reg2;
    logic [rv_isa_pkg::XLEN-1:0]   op1;
    logic [rv_isa_pkg::XLEN-1:0]   op2;
    logic [4:0]                    shamt;
    logic [rv_isa_pkg::XLEN-1:0]   result;

    // instruction one ahead writes a real register
    assign fwd_ok = fwd.valid && fwd.reg_write && (fwd.rd != '0);

    // distance-1 forwarding, older values come through the register file
    assign reg1 = (fwd_ok && (fwd.rd == id_ex.rs1)) ? fwd.result : id_ex.read1;
    assign reg2 = (fwd_ok && (fwd.rd == id_ex.rs2)) ? fwd.result : id_ex.read2;

    // operand 1 source
    always_comb begin
        case (id_ex.alu_src1)
            pipe_ctrl_pkg::SEL_PC:   op1 = id_ex.pc;
            pipe_ctrl_pkg::SEL_ZERO: op1 = '0;
            default:                 op1 = reg1;
        endcase
    end

    // operand 2 source
    assign op2   = (id_ex.alu_src2 == pipe_ctrl_pkg::SEL_IMM) ? id_ex.imm : reg2;
    assign shamt = op2[4:0];

    always_comb begin
        case (id_ex.alu_op)
            pipe_ctrl_pkg::ALU_ADD:   result = op1 + op2;
            pipe_ctrl_pkg::ALU_SUB:   result = op1 - op2;
            pipe_ctrl_pkg::ALU_SLL:   result = op1 << shamt;
            pipe_ctrl_pkg::ALU_SLT:   result = {31'b0, $signed(op1) < $signed(op2)};
            pipe_ctrl_pkg::ALU_SLTU:  result = {31'b0, op1 < op2};
            pipe_ctrl_pkg::ALU_XOR:   result = op1 ^ op2;
            pipe_ctrl_pkg::ALU_SRL:   result = op1 >> shamt;
            pipe_ctrl_pkg::ALU_SRA:   result = $unsigned($signed(op1) >>> shamt);
            pipe_ctrl_pkg::ALU_OR:    result = op1 | op2;
            pipe_ctrl_pkg::ALU_AND:   result = op1 & op2;
            pipe_ctrl_pkg::ALU_PASS2: result = op2;
            default:                  result = '0;
        endcase
    end

    // control fields pass straight through
    always_comb begin
        ex_wb.valid     = id_ex.valid;
        ex_wb.reg_write = id_ex.reg_write;
        ex_wb.rd        = id_ex.rd;
        ex_wb.result    = result;
    end

endmodule

`default_nettype wire

// ==== hw/int_pipeline_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_pipeline_top (
    input  wire logic                           clk,
    input  wire logic                           rstN,
    input  wire logic                           in_valid,
    input  wire logic [31:0]                    instr,
    input  wire logic [rv_isa_pkg::XLEN-1:0]    pc,
    output logic                                wb_valid,
    output rv_isa_pkg::reg_name_t               wb_rd,
    output logic [rv_isa_pkg::XLEN-1:0]         wb_data
);

    pipe_ctrl_pkg::if_id_t          if_id_d;
    pipe_ctrl_pkg::if_id_t          if_id_q;
    pipe_ctrl_pkg::id_ex_t          id_ex_d;
    pipe_ctrl_pkg::id_ex_t          id_ex_q;
    pipe_ctrl_pkg::ex_wb_t          ex_wb_d;
    pipe_ctrl_pkg::ex_wb_t          ex_wb_q;

    rv_isa_pkg::reg_name_t          rs1;
    rv_isa_pkg::reg_name_t          rs2;
    logic [rv_isa_pkg::XLEN-1:0]    rdata1;
    logic [rv_isa_pkg::XLEN-1:0]    rdata2;
    logic                           rf_we;

    // incoming instruction
    assign if_id_d = '{valid: in_valid, pc: pc, instr: instr};

    pipeline_register #(.payload_t(pipe_ctrl_pkg::if_id_t)) u_if_id (
        .clk  (clk),
        .rstN (rstN),
        .d    (if_id_d),
        .q    (if_id_q)
    );

    decode_stage u_decode (
        .if_id  (if_id_q),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .id_ex  (id_ex_d)
    );

    register_file u_regfile (
        .clk    (clk),
        .rstN   (rstN),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (ex_wb_q.rd),
        .wdata  (ex_wb_q.result)
    );

    pipeline_register #(.payload_t(pipe_ctrl_pkg::id_ex_t)) u_id_ex (
        .clk  (clk),
        .rstN (rstN),
        .d    (id_ex_d),
        .q    (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex (id_ex_q),
        .fwd   (ex_wb_q),
        .ex_wb (ex_wb_d)
    );

    pipeline_register #(.payload_t(pipe_ctrl_pkg::ex_wb_t)) u_ex_wb (
        .clk  (clk),
        .rstN (rstN),
        .d    (ex_wb_d),
        .q    (ex_wb_q)
    );

    // writeback, x0 is never written
    assign rf_we = ex_wb_q.valid && ex_wb_q.reg_write && (ex_wb_q.rd != '0);

    assign wb_valid = ex_wb_q.valid;
    assign wb_rd    = ex_wb_q.rd;
    assign wb_data  = ex_wb_q.result;

endmodule

`default_nettype wire

// ==== tests/tb_int_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipeline;

    localparam int          MAX_ROWS      = 40;
    localparam int          RETIRE_LIMIT  = 30;
    localparam logic [31:0] PC_BASE       = 32'h0000_2000;

    // short func3/func7 names for the table
    localparam logic [2:0] F_ADD  = rv_isa_pkg::FUNC3_ADD_SUB;
    localparam logic [2:0] F_SLL  = rv_isa_pkg::FUNC3_SLL;
    localparam logic [2:0] F_SLT  = rv_isa_pkg::FUNC3_SLT;
    localparam logic [2:0] F_SLTU = rv_isa_pkg::FUNC3_SLTU;
    localparam logic [2:0] F_XOR  = rv_isa_pkg::FUNC3_XOR;
    localparam logic [2:0] F_SR   = rv_isa_pkg::FUNC3_SR;
    localparam logic [2:0] F_OR   = rv_isa_pkg::FUNC3_OR;
    localparam logic [2:0] F_AND  = rv_isa_pkg::FUNC3_AND;
    localparam logic [6:0] F7_ALT = rv_isa_pkg::FUNC7_ALT;

    // one stimulus row with its expected writeback
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        retires;
        logic [4:0]  rd;
        logic [31:0] data;
    } row_t;

    logic                   clk = 1'b0;
    logic                   rstN;
    logic                   in_valid;
    logic [31:0]            instr;
    logic [31:0]            pc;
    logic                   wb_valid;
    rv_isa_pkg::reg_name_t  wb_rd;
    logic [31:0]            wb_data;

    row_t rows [0:MAX_ROWS-1];
    int   num_rows;
    int   expected_retires;
    int   check_idx;
    int   retired;
    int   errors;

    always #20 clk = ~clk;

    int_pipeline_top i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .in_valid (in_valid),
        .instr    (instr),
        .pc       (pc),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    function automatic logic [31:0] r_type(
        input logic [6:0] f7,
        input logic [4:0] rs2,
        input logic [4:0] rs1,
        input logic [2:0] f3,
        input logic [4:0] rd
    );
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(
        input logic [11:0] imm,
        input logic [4:0]  rs1,
        input logic [2:0]  f3,
        input logic [4:0]  rd
    );
        return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type(
        input logic [6:0]  opc,
        input logic [19:0] imm,
        input logic [4:0]  rd
    );
        return {imm, rd, opc};
    endfunction

    // pc of each row follows from its position
    task automatic add_row(
        input logic [31:0] word,
        input logic        retires,
        input logic [4:0]  rd,
        input logic [31:0] data
    );
        rows[num_rows] = '{instr: word, pc: PC_BASE + 32'(4 * num_rows),
                           retires: retires, rd: rd, data: data};
        num_rows++;
        if (retires) begin
            expected_retires++;
        end
    endtask

    task automatic build_table();
        num_rows         = 0;
        expected_retires = 0;
        // x0 reads zero, then OP-IMM with x1 = 5 and x2 = -3
        add_row(i_type(12'h005, 5'd0, F_ADD, 5'd1), 1'b1, 5'd1, 32'h0000_0005);
        add_row(i_type(12'hFFD, 5'd0, F_ADD, 5'd2), 1'b1, 5'd2, 32'hFFFF_FFFD);
        add_row(i_type(12'h001, 5'd2, F_SLT, 5'd3), 1'b1, 5'd3, 32'h0000_0001);
        add_row(i_type(12'h001, 5'd2, F_SLTU, 5'd4), 1'b1, 5'd4, 32'h0000_0000);
        add_row(i_type(12'h0F0, 5'd1, F_XOR, 5'd5), 1'b1, 5'd5, 32'h0000_00F5);
        add_row(i_type(12'h700, 5'd1, F_OR, 5'd6), 1'b1, 5'd6, 32'h0000_0705);
        add_row(i_type(12'h0FF, 5'd2, F_AND, 5'd7), 1'b1, 5'd7, 32'h0000_00FD);
        add_row(i_type(12'h004, 5'd2, F_SLL, 5'd8), 1'b1, 5'd8, 32'hFFFF_FFD0);
        add_row(i_type(12'h004, 5'd2, F_SR, 5'd9), 1'b1, 5'd9, 32'h0FFF_FFFF);
        // srai carries func7 in the upper immediate bits
        add_row(i_type({F7_ALT, 5'd4}, 5'd2, F_SR, 5'd10), 1'b1, 5'd10, 32'hFFFF_FFFF);
        // R-type on x1 and x2
        add_row(r_type(7'd0, 5'd2, 5'd1, F_ADD, 5'd11), 1'b1, 5'd11, 32'h0000_0002);
        add_row(r_type(F7_ALT, 5'd2, 5'd1, F_ADD, 5'd12), 1'b1, 5'd12, 32'h0000_0008);
        add_row(r_type(7'd0, 5'd1, 5'd1, F_SLL, 5'd13), 1'b1, 5'd13, 32'h0000_00A0);
        add_row(r_type(7'd0, 5'd1, 5'd2, F_SLT, 5'd14), 1'b1, 5'd14, 32'h0000_0001);
        add_row(r_type(7'd0, 5'd1, 5'd2, F_SLTU, 5'd15), 1'b1, 5'd15, 32'h0000_0000);
        add_row(r_type(7'd0, 5'd2, 5'd1, F_XOR, 5'd16), 1'b1, 5'd16, 32'hFFFF_FFF8);
        add_row(r_type(7'd0, 5'd1, 5'd2, F_SR, 5'd17), 1'b1, 5'd17, 32'h07FF_FFFF);
        add_row(r_type(F7_ALT, 5'd1, 5'd2, F_SR, 5'd18), 1'b1, 5'd18, 32'hFFFF_FFFF);
        add_row(r_type(7'd0, 5'd2, 5'd1, F_OR, 5'd19), 1'b1, 5'd19, 32'hFFFF_FFFD);
        add_row(r_type(7'd0, 5'd2, 5'd1, F_AND, 5'd20), 1'b1, 5'd20, 32'h0000_0005);
        // dependency chain at distances 1, 2 and 3
        add_row(i_type(12'h064, 5'd0, F_ADD, 5'd21), 1'b1, 5'd21, 32'h0000_0064);
        add_row(i_type(12'h001, 5'd21, F_ADD, 5'd22), 1'b1, 5'd22, 32'h0000_0065);
        add_row(r_type(7'd0, 5'd22, 5'd21, F_ADD, 5'd23), 1'b1, 5'd23, 32'h0000_00C9);
        add_row(r_type(7'd0, 5'd23, 5'd21, F_ADD, 5'd24), 1'b1, 5'd24, 32'h0000_012D);
        // x0 write still shows its result, a later read of x0 gives zero
        add_row(i_type(12'h007, 5'd0, F_ADD, 5'd0), 1'b1, 5'd0, 32'h0000_0007);
        add_row(r_type(7'd0, 5'd0, 5'd0, F_ADD, 5'd25), 1'b1, 5'd25, 32'h0000_0000);
        // upper immediates, rows 27 and 28 sit at pc 0x206c and 0x2070
        add_row(u_type(rv_isa_pkg::OPC_LUI, 20'h12345, 5'd26), 1'b1, 5'd26, 32'h1234_5000);
        add_row(u_type(rv_isa_pkg::OPC_AUIPC, 20'h00001, 5'd27), 1'b1, 5'd27, 32'h0000_306C);
        add_row(u_type(rv_isa_pkg::OPC_AUIPC, 20'hFFFFF, 5'd28), 1'b1, 5'd28, 32'h0000_1070);
        add_row(r_type(7'd0, 5'd27, 5'd26, F_ADD, 5'd29), 1'b1, 5'd29, 32'h1234_806C);
        // sw x1, 0(x2) is not supported and must vanish
        add_row({7'd0, 5'd1, 5'd2, 3'b010, 5'd0, 7'b0100011}, 1'b0, 5'd0, 32'h0);
        add_row(i_type(12'h001, 5'd29, F_ADD, 5'd30), 1'b1, 5'd30, 32'h1234_806D);
        add_row(r_type(F7_ALT, 5'd28, 5'd30, F_ADD, 5'd31), 1'b1, 5'd31, 32'h1234_6FFD);
    endtask

    // retirement checker, one table row per wb_valid pulse
    initial begin : retire_check
        row_t exp_row;
        check_idx = 0;
        retired   = 0;
        forever begin
            @(negedge clk);
            if (rstN === 1'b1 && wb_valid === 1'b1) begin
                while (check_idx < num_rows && !rows[check_idx].retires) begin
                    check_idx++;
                end
                if (check_idx >= num_rows) begin
                    errors++;
                    $display("writeback pulse seen with no instruction left to retire");
                end else begin
                    exp_row = rows[check_idx];
                    if (wb_rd !== exp_row.rd) begin
                        errors++;
                        $display("ERROR wb_rd row %0d: expected %h, got %h",
                                 check_idx, exp_row.rd, wb_rd);
                    end
                    if (wb_data !== exp_row.data) begin
                        errors++;
                        $display("ERROR wb_data row %0d: expected %h, got %h",
                                 check_idx, exp_row.data, wb_data);
                    end
                    check_idx++;
                    retired++;
                end
            end
        end
    end

    initial begin : main
        int row_idx;
        int wait_cycles;
        errors    = 0;
        rstN      = 1'b0;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        void'($urandom(32'h735));
        build_table();

        repeat (5) @(posedge clk);
        rstN  <= 1'b1;
        // a supported word sits on the bus, only in_valid keeps it out
        instr <= rows[0].instr;

        // idle after reset, nothing may retire
        repeat (4) begin
            @(negedge clk);
            if (wb_valid !== 1'b0) begin
                errors++;
                $display("ERROR wb_valid: expected %h, got %h", 1'b0, wb_valid);
            end
        end

        for (row_idx = 0; row_idx < num_rows; row_idx++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            instr    <= rows[row_idx].instr;
            pc       <= rows[row_idx].pc;
            // occasional bubble stretches the dependency distances
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        wait_cycles = 0;
        while (retired < expected_retires && wait_cycles < RETIRE_LIMIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (retired < expected_retires) begin
            errors++;
            $display("timeout: %0d instructions were lost in the pipeline",
                     expected_retires - retired);
        end

        // a few quiet cycles to catch stray pulses
        repeat (4) @(negedge clk);

        $display("errors: %0d, retired: %0d of %0d", errors, retired, expected_retires);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
hw/rv_isa_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/pipeline_register.sv
hw/decode_stage.sv
hw/register_file.sv
hw/execute_stage.sv
hw/int_pipeline_top.sv
tests/tb_int_pipeline.sv

// ==== Bender.yml ====
package:
  name: int_pipeline

sources:
  # packages first, then the pipeline from leaves to top
  - hw/rv_isa_pkg.sv
  - hw/pipe_ctrl_pkg.sv
  - hw/pipeline_register.sv
  - hw/decode_stage.sv
  - hw/register_file.sv
  - hw/execute_stage.sv
  - hw/int_pipeline_top.sv
  - target: test
    files:
      - tests/tb_int_pipeline.sv
